// File: tb.f
+incdir+verif
common/csr_pkg.sv
csr/csr_cmd_decode.sv
csr/csr_stage.sv
src/trap_redirect.sv
src/csr_unit_top.sv
verif/csr_tb.sv

// File: run.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f tb.f \
    --top-module csr_tb \
    -o csr_sim

./obj_dir/csr_sim

// File: verif/csr_model.svh
`ifndef CSR_MODEL_SVH
`define CSR_MODEL_SVH

// architectural CSR state with every accepted command applied.
xlen_word_t model_csr [CSR_DEPTH];
logic       model_flush; // next cycle sits in an ecall shadow.

function automatic int model_idx(input csr_addr_t a);
    return int'(a) % int'(CSR_DEPTH);
endfunction

task automatic model_reset();
    for (int i = 0; i < int'(CSR_DEPTH); i++) begin
        model_csr[i] = '0;
    end
    model_csr[model_idx(MTVEC_ADDR)] = MTVEC_RESET;
    model_flush = 1'b0;
endtask

// one cycle of the CSR unit, returns 1 when the command is accepted.
function automatic logic model_apply(
    input  logic       squash_in,
    input  logic       sys_in,
    input  logic       ecall_in,
    input  logic [2:0] f3,
    input  logic [4:0] rs1,
    input  xlen_word_t data,
    input  csr_addr_t  a,
    output xlen_word_t rd,
    output xlen_word_t nv,
    output logic       redirect
);
    csr_cmd_e   c;
    xlen_word_t op;
    int         i;
    logic       acc;

    c  = CSR_X;
    op = f3[2] ? xlen_word_t'(rs1) : data;
    i  = model_idx(a);
    if (ecall_in) begin
        c = CSR_E;
        i = model_idx(MCAUSE_ADDR);
    end else if (sys_in) begin
        case (f3)
            3'b001, 3'b101: c = CSR_W;
            3'b010, 3'b110: c = (rs1 == 5'd0) ? CSR_R : CSR_S;
            3'b011, 3'b111: c = (rs1 == 5'd0) ? CSR_R : CSR_C;
            default:        c = CSR_X;
        endcase
    end
    acc = (c != CSR_X) && !squash_in && !model_flush;
    rd  = model_csr[i];
    case (c)
        CSR_W:   nv = op;
        CSR_S:   nv = rd | op;
        CSR_C:   nv = rd & ~op;
        CSR_E:   nv = ECALL_CAUSE;
        default: nv = rd;
    endcase
    redirect    = acc && (c == CSR_E);
    model_flush = redirect;
    if (acc) begin
        model_csr[i] = nv;
    end
    return acc;
endfunction

`endif

// File: verif/csr_tb.sv
`timescale 1ns/100ps

module csr_tb;
    import csr_pkg::*;

    localparam int unsigned CSR_DEPTH   = 64;
    localparam xlen_word_t  MTVEC_RESET = 32'h0000_0100;
    localparam int          WAIT_LIMIT  = 50;
    localparam int          MIX_CYCLES  = 3000;

    logic       clk;
    logic       rst_n;
    logic       squash;
    logic       is_system;
    logic       is_ecall;
    logic [2:0] funct3;
    logic [4:0] rs1_idx;
    xlen_word_t rs1_data;
    csr_addr_t  csr_addr;
    xlen_word_t csr_rdata;
    logic       rdata_valid;
    xlen_word_t trap_vector;
    logic       redirect_valid;
    xlen_word_t redirect_pc;

    // expected outputs, this cycle and the next one.
    logic       exp_valid_cur;
    logic       exp_valid_nxt;
    xlen_word_t exp_rdata_cur;
    xlen_word_t exp_rdata_nxt;
    logic       exp_redir_cur;
    logic       exp_redir_nxt;
    xlen_word_t exp_tvec_cur;
    xlen_word_t exp_tvec_nxt;
    xlen_word_t last_nv;
    logic       checks_on;
    string      test_name;

    `include "csr_model.svh"

    csr_unit_top #(
        .CSR_DEPTH   (CSR_DEPTH),
        .MTVEC_RESET (MTVEC_RESET)
    ) dut0 (
        .clk            (clk),
        .rst_n          (rst_n),
        .squash         (squash),
        .is_system      (is_system),
        .is_ecall       (is_ecall),
        .funct3         (funct3),
        .rs1_idx        (rs1_idx),
        .rs1_data       (rs1_data),
        .csr_addr       (csr_addr),
        .csr_rdata      (csr_rdata),
        .rdata_valid    (rdata_valid),
        .trap_vector    (trap_vector),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_word(input string what, input xlen_word_t exp, input xlen_word_t act);
        if (exp !== act) begin
            abort_run($sformatf("MISMATCH %s %s: expected %h actual %h",
                                test_name, what, exp, act));
        end
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        if (exp !== act) begin
            abort_run($sformatf("MISMATCH %s %s: expected %b actual %b",
                                test_name, what, exp, act));
        end
    endtask

    // outputs are settled by the falling edge.
    always @(negedge clk) begin
        if (checks_on) begin
            check_bit("rdata_valid", exp_valid_cur, rdata_valid);
            if (exp_valid_cur) begin
                check_word("csr_rdata", exp_rdata_cur, csr_rdata);
            end
            check_bit("redirect_valid", exp_redir_cur, redirect_valid);
            check_word("trap_vector", exp_tvec_cur, trap_vector);
            if (exp_redir_cur) begin
                check_word("redirect_pc", exp_tvec_cur, redirect_pc);
            end
        end
    end

    task automatic drive_cycle(
        input logic       sq,
        input logic       sys,
        input logic       ec,
        input logic [2:0] f3,
        input logic [4:0] rs1,
        input xlen_word_t data,
        input csr_addr_t  a
    );
        xlen_word_t rd;
        xlen_word_t nv;
        logic       redir;
        logic       acc;

        @(posedge clk);
        #2;
        squash    = sq;
        is_system = sys;
        is_ecall  = ec;
        funct3    = f3;
        rs1_idx   = rs1;
        rs1_data  = data;
        csr_addr  = a;
        exp_valid_cur = exp_valid_nxt;
        exp_rdata_cur = exp_rdata_nxt;
        exp_redir_cur = exp_redir_nxt;
        exp_tvec_cur  = exp_tvec_nxt;
        exp_tvec_nxt  = model_csr[model_idx(MTVEC_ADDR)]; // commits seen one cycle late.
        acc = model_apply(sq, sys, ec, f3, rs1, data, a, rd, nv, redir);
        exp_valid_nxt = acc;
        exp_rdata_nxt = rd;
        exp_redir_nxt = redir;
        last_nv       = nv;
    endtask

    task automatic idle();
        drive_cycle(1'b0, 1'b0, 1'b0, 3'b000, 5'd0, '0, 12'h000);
    endtask

    task automatic csr_op(input logic [2:0] f3, input logic [4:0] rs1,
                          input xlen_word_t data, input csr_addr_t a);
        drive_cycle(1'b0, 1'b1, 1'b0, f3, rs1, data, a);
    endtask

    task automatic ecall();
        drive_cycle(1'b0, 1'b0, 1'b1, 3'b000, 5'd0, '0, 12'h000);
    endtask

    task automatic wait_rdata(output xlen_word_t data);
        for (int n = 0; n < WAIT_LIMIT; n++) begin
            idle();
            if (rdata_valid) begin
                data = csr_rdata;
                return;
            end
        end
        abort_run($sformatf("%s: rdata_valid never came within %0d cycles",
                            test_name, WAIT_LIMIT));
    endtask

    task automatic wait_redirect(output xlen_word_t pc);
        for (int n = 0; n < WAIT_LIMIT; n++) begin
            idle();
            if (redirect_valid) begin
                pc = redirect_pc;
                return;
            end
        end
        abort_run($sformatf("%s: redirect_valid never came within %0d cycles",
                            test_name, WAIT_LIMIT));
    endtask

    // csrrs with x0 reads without writing.
    task automatic read_csr(input csr_addr_t a, output xlen_word_t data);
        csr_op(3'b010, 5'd0, '0, a);
        wait_rdata(data);
    endtask

    initial begin
        xlen_word_t got;
        xlen_word_t want;
        logic [31:0] r;
        logic [1:0]  sel;
        csr_addr_t   a;

        rst_n     = 1'b0;
        squash    = 1'b0;
        is_system = 1'b0;
        is_ecall  = 1'b0;
        funct3    = 3'b000;
        rs1_idx   = 5'd0;
        rs1_data  = '0;
        csr_addr  = '0;
        checks_on = 1'b0;
        test_name = "reset";
        void'($urandom(32'hba8b_589d));
        model_reset();
        exp_valid_cur = 1'b0;
        exp_valid_nxt = 1'b0;
        exp_rdata_cur = '0;
        exp_rdata_nxt = '0;
        exp_redir_cur = 1'b0;
        exp_redir_nxt = 1'b0;
        exp_tvec_cur  = MTVEC_RESET;
        exp_tvec_nxt  = MTVEC_RESET;
        last_nv       = '0;
        repeat (8) @(posedge clk);
        #2;
        rst_n     = 1'b1;
        checks_on = 1'b1;

        check_bit("rdata_valid", 1'b0, rdata_valid);
        check_bit("redirect_valid", 1'b0, redirect_valid);
        check_word("trap_vector", MTVEC_RESET, trap_vector);
        read_csr(MTVEC_ADDR, got);
        check_word("mtvec", MTVEC_RESET, got);
        read_csr(MCAUSE_ADDR, got);
        check_word("mcause", '0, got);

        test_name = "rmw";
        for (int k = 0; k < 40; k++) begin
            r   = $urandom;
            sel = (r[2:1] == 2'b00) ? 2'b01 : r[2:1];
            a   = r[19:8];
            csr_op({r[0], sel}, (r[7:3] == 5'd0) ? 5'd1 : r[7:3], $urandom, a);
            want = last_nv;
            read_csr(a, got);
            check_word("readback", want, got);
        end

        test_name = "read_only_forward";
        csr_op(3'b001, 5'd2, 32'h00f0_0f0f, 12'h030);
        csr_op(3'b010, 5'd0, 32'hffff_ffff, 12'h030); // x0 set, no write.
        csr_op(3'b011, 5'd0, 32'hffff_ffff, 12'h030);
        csr_op(3'b010, 5'd6, 32'h1100_0000, 12'h030);
        csr_op(3'b111, 5'h0f, '0, 12'h030);
        read_csr(12'h030, got);
        check_word("chained result", 32'h11f0_0f00, got);

        test_name = "squash";
        csr_op(3'b001, 5'd1, 32'hcafe_0001, 12'h021);
        drive_cycle(1'b1, 1'b1, 1'b0, 3'b001, 5'd1, 32'h0bad_0bad, 12'h021);
        drive_cycle(1'b1, 1'b1, 1'b0, 3'b110, 5'd7, '0, 12'h021);
        check_bit("squashed rdata_valid", 1'b0, rdata_valid);
        drive_cycle(1'b1, 1'b0, 1'b1, 3'b000, 5'd0, '0, 12'h000);
        idle();
        check_bit("squashed ecall", 1'b0, redirect_valid);
        read_csr(12'h021, got);
        check_word("after squash", 32'hcafe_0001, got);

        test_name = "ecall";
        csr_op(3'b001, 5'd3, 32'h0000_005a, MCAUSE_ADDR);
        csr_op(3'b001, 5'd4, 32'h1234_5678, 12'h010);
        idle();
        want = model_csr[model_idx(MTVEC_ADDR)];
        ecall();
        csr_op(3'b001, 5'd4, 32'hdead_beef, 12'h010); // lands in the shadow.
        check_bit("redirect pulse", 1'b1, redirect_valid);
        check_word("redirect target", want, redirect_pc);
        check_bit("ecall rdata_valid", 1'b1, rdata_valid);
        check_word("old mcause", 32'h0000_005a, csr_rdata);
        idle();
        check_bit("single pulse", 1'b0, redirect_valid);
        read_csr(12'h010, got);
        check_word("shadow dropped", 32'h1234_5678, got);
        read_csr(MCAUSE_ADDR, got);
        check_word("mcause", ECALL_CAUSE, got);
        csr_op(3'b001, 5'd5, 32'h0000_0800, MTVEC_ADDR);
        idle();
        idle();
        check_word("trap_vector update", 32'h0000_0800, trap_vector);
        ecall();
        wait_redirect(got);
        check_word("new target", 32'h0000_0800, got);

        test_name = "random_mix";
        for (int k = 0; k < MIX_CYCLES; k++) begin
            r = $urandom;
            case (r[19:18])
                2'b00:   a = MTVEC_ADDR;
                2'b01:   a = MCAUSE_ADDR;
                default: a = r[31:20];
            endcase
            drive_cycle(r[3:0] == 4'd0,
                        (r[7:4] >= 4'd2) && (r[7:4] < 4'd14),
                        r[7:4] < 4'd2,
                        r[10:8],
                        (r[12:11] == 2'b00) ? 5'd0 : r[17:13],
                        $urandom,
                        a);
        end
        repeat (4) idle();

        $display("=== PASS ===");
        $finish;
    end

endmodule

// File: src/csr_unit_top.sv
`timescale 1ns/100ps

module csr_unit_top #(
    parameter int unsigned         CSR_DEPTH   = 64,
    parameter csr_pkg::xlen_word_t MTVEC_RESET = 32'h0000_0100
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                squash,
    input  logic                is_system,
    input  logic                is_ecall,
    input  logic [2:0]          funct3,
    input  logic [4:0]          rs1_idx,
    input  csr_pkg::xlen_word_t rs1_data,
    input  csr_pkg::csr_addr_t  csr_addr,
    output csr_pkg::xlen_word_t csr_rdata,
    output logic                rdata_valid,
    output csr_pkg::xlen_word_t trap_vector,
    output logic                redirect_valid,
    output csr_pkg::xlen_word_t redirect_pc
);
    import csr_pkg::*;

    csr_cmd_e   cmd;
    xlen_word_t op1;
    csr_addr_t  addr;
    logic       ecall_taken;
    logic       trap_flush;

    csr_cmd_decode u_decode (
        .is_system (is_system),
        .is_ecall  (is_ecall),
        .funct3    (funct3),
        .rs1_idx   (rs1_idx),
        .rs1_data  (rs1_data),
        .csr_addr  (csr_addr),
        .cmd       (cmd),
        .op1       (op1),
        .addr      (addr)
    );

    csr_stage #(
        .CSR_DEPTH   (CSR_DEPTH),
        .MTVEC_RESET (MTVEC_RESET)
    ) u_stage (
        .clk         (clk),
        .rst_n       (rst_n),
        .squash      (squash),
        .trap_flush  (trap_flush),
        .cmd         (cmd),
        .op1         (op1),
        .addr        (addr),
        .csr_rdata   (csr_rdata),
        .rdata_valid (rdata_valid),
        .trap_vector (trap_vector),
        .ecall_taken (ecall_taken)
    );

    trap_redirect u_redirect (
        .clk            (clk),
        .rst_n          (rst_n),
        .ecall_taken    (ecall_taken),
        .trap_vector    (trap_vector),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .trap_flush     (trap_flush)
    );

endmodule

// File: src/trap_redirect.sv
`timescale 1ns/100ps

module trap_redirect (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                ecall_taken,
    input  csr_pkg::xlen_word_t trap_vector,
    output logic                redirect_valid,
    output csr_pkg::xlen_word_t redirect_pc,
    output logic                trap_flush
);

    // one-cycle pulse in the cycle after the ecall is accepted.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            redirect_valid <= 1'b0;
        end else begin
            redirect_valid <= ecall_taken;
        end
    end

    // target follows mtvec as seen this cycle.
    assign redirect_pc = trap_vector;

    // kill the instruction in the ecall shadow.
    assign trap_flush = redirect_valid;

    a_single_pulse: assert property (
        @(posedge clk) disable iff (!rst_n)
        redirect_valid |=> !redirect_valid
    ) else $error("trap_redirect: redirect_valid high two cycles in a row.");

endmodule

// File: csr/csr_stage.sv
`timescale 1ns/100ps

module csr_stage #(
    parameter int unsigned         CSR_DEPTH   = 64,
    parameter csr_pkg::xlen_word_t MTVEC_RESET = 32'h0000_0100
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                squash,
    input  logic                trap_flush,
    input  csr_pkg::csr_cmd_e   cmd,
    input  csr_pkg::xlen_word_t op1,
    input  csr_pkg::csr_addr_t  addr,
    output csr_pkg::xlen_word_t csr_rdata,
    output logic                rdata_valid,
    output csr_pkg::xlen_word_t trap_vector,
    output logic                ecall_taken
);
    import csr_pkg::*;

    localparam int IDX_W = $clog2(CSR_DEPTH);

    typedef logic [IDX_W-1:0] csr_idx_t;

    localparam csr_idx_t MTVEC_IDX = csr_idx_t'(MTVEC_ADDR % CSR_DEPTH);

    xlen_word_t mem [CSR_DEPTH];

    logic       accept;
    csr_idx_t   idx;
    xlen_word_t rd_next;

    // second stage, the command waiting to commit.
    csr_cmd_e   save_cmd;
    csr_idx_t   save_idx;
    xlen_word_t save_op1;
    xlen_word_t wdata;
    logic       wr_en;

    assign idx         = addr[IDX_W-1:0]; // address modulo depth.
    assign accept      = (cmd != CSR_X) && !squash && !trap_flush;
    assign ecall_taken = accept && (cmd == CSR_E);

    // csr_rdata still holds the old value of the saved entry here.
    always_comb begin
        case (save_cmd)
            CSR_W:   wdata = save_op1;
            CSR_S:   wdata = csr_rdata | save_op1;
            CSR_C:   wdata = csr_rdata & ~save_op1;
            CSR_E:   wdata = ECALL_CAUSE;
            default: wdata = csr_rdata;
        endcase
    end

    assign wr_en = save_cmd inside {CSR_W, CSR_S, CSR_C, CSR_E};

    // forward the pending write to a read of the same entry.
    assign rd_next = (wr_en && (save_idx == idx)) ? wdata : mem[idx];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rdata_valid <= 1'b0;
            save_cmd    <= CSR_X;
            csr_rdata   <= '0;
            trap_vector <= MTVEC_RESET;
        end else begin
            rdata_valid <= accept;
            save_cmd    <= accept ? cmd : CSR_X;
            if (accept) begin
                csr_rdata <= rd_next;
            end
            // track the commit so a new mtvec shows one cycle after the write.
            if (wr_en && (save_idx == MTVEC_IDX)) begin
                trap_vector <= wdata;
            end else begin
                trap_vector <= mem[MTVEC_IDX];
            end
        end
    end

    always_ff @(posedge clk) begin
        save_idx <= idx;
        save_op1 <= op1;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < CSR_DEPTH; i++) begin
                mem[i] <= (i == int'(MTVEC_IDX)) ? MTVEC_RESET : '0;
            end
        end else if (wr_en) begin
            mem[save_idx] <= wdata; // commit at end of the second cycle.
        end
    end

    a_killed_no_write: assert property (
        @(posedge clk) disable iff (!rst_n)
        ((cmd != CSR_X) && (squash || trap_flush)) |=> !wr_en
    ) else $error("csr_stage: killed command reached the write port.");

    a_valid_has_cmd: assert property (
        @(posedge clk) disable iff (!rst_n)
        rdata_valid |-> (save_cmd != CSR_X)
    ) else $error("csr_stage: rdata_valid without a saved command.");

endmodule

// File: csr/csr_cmd_decode.sv
`timescale 1ns/100ps

module csr_cmd_decode (
    input  logic                is_system,
    input  logic                is_ecall,
    input  logic [2:0]          funct3,
    input  logic [4:0]          rs1_idx,
    input  csr_pkg::xlen_word_t rs1_data,
    input  csr_pkg::csr_addr_t  csr_addr,
    output csr_pkg::csr_cmd_e   cmd,
    output csr_pkg::xlen_word_t op1,
    output csr_pkg::csr_addr_t  addr
);
    import csr_pkg::*;

    logic rs1_is_x0;

    assign rs1_is_x0 = (rs1_idx == 5'd0);

    // funct3[2] picks the immediate form, funct3[1:0] the operation.
    always_comb begin
        cmd  = CSR_X;
        op1  = '0;
        addr = csr_addr;
        if (is_ecall) begin
            cmd  = CSR_E;
            addr = MCAUSE_ADDR; // ecall always touches mcause.
        end else if (is_system) begin
            if (funct3[2]) begin
                op1 = xlen_word_t'(rs1_idx); // zero-extended uimm.
            end else begin
                op1 = rs1_data;
            end
            case (funct3[1:0])
                2'b01: begin
                    cmd = CSR_W;
                end
                2'b10: begin
                    cmd = rs1_is_x0 ? CSR_R : CSR_S; // x0 means no write.
                end
                2'b11: begin
                    cmd = rs1_is_x0 ? CSR_R : CSR_C;
                end
                default: begin
                    cmd = CSR_X;
                end
            endcase
        end
    end

    // the front end flags ecall apart from the CSR forms of SYSTEM.
    always_comb begin
        a_one_system_kind: assert final (!(is_system && is_ecall))
            else $error("csr_cmd_decode: is_system and is_ecall high together.");
    end

endmodule

// File: common/csr_pkg.sv
package csr_pkg;

    // data word carried through the CSR path.
    typedef logic [31:0] xlen_word_t;

    // 12-bit CSR address from the instruction.
    typedef logic [11:0] csr_addr_t;

    typedef enum logic [2:0] {
        CSR_X = 3'd0, // none or squashed.
        CSR_R = 3'd1, // read only.
        CSR_W = 3'd2, // write.
        CSR_S = 3'd3, // set bits.
        CSR_C = 3'd4, // clear bits.
        CSR_E = 3'd5  // ecall.
    } csr_cmd_e;

    localparam csr_addr_t  MTVEC_ADDR  = 12'h305; // trap vector base.
    localparam csr_addr_t  MCAUSE_ADDR = 12'h342; // trap cause.
    localparam xlen_word_t ECALL_CAUSE = 32'd11;  // environment call from M-mode.

endpackage
